//--- hdl/mprj_ctrl_pkg.sv
package mprj_ctrl_pkg;

    // Sizes
    localparam int IO_PADS      = 8;
    localparam int PWR_PADS     = 8;
    localparam int IO_CTRL_BITS = 13;
    localparam int BIT_CNT_W    = $clog2(IO_CTRL_BITS);

    // Bit positions inside a pad control word
    localparam int OEB_BIT      = 1;   // Output enable, active low
    localparam int INP_DIS_BIT  = 3;   // Input disable

    typedef logic [31:0]                  bus_addr_t;
    typedef logic [31:0]                  bus_data_t;
    typedef logic [IO_CTRL_BITS-1:0]      pad_ctrl_t;
    typedef logic [IO_PADS-1:0]           pad_vec_t;
    typedef logic [PWR_PADS-1:0]          pwr_vec_t;
    typedef logic [$clog2(IO_PADS)-1:0]   pad_idx_t;

    // Address map, only bits 31:8 of the base are decoded
    localparam bus_addr_t  BASE_ADR     = 32'h2300_0000;
    localparam logic [7:0] XFER_OFS     = 8'h00;
    localparam logic [7:0] PWRDATA_OFS  = 8'h04;
    localparam logic [7:0] IODATA_OFS   = 8'h08;
    localparam logic [7:0] IOCONFIG_OFS = 8'h20;   // Pad i at IOCONFIG_OFS + 4*i

    // Control word reset values
    localparam pad_ctrl_t CTRL_RST_BIDIR = 13'h1803;   // Pads 0 and 1
    localparam pad_ctrl_t CTRL_RST_INPUT = 13'h0403;   // Plain input pads

    typedef enum logic [1:0] {
        LDR_IDLE,
        LDR_START,
        LDR_SHIFT,
        LDR_LATCH
    } loader_state_t;

endpackage

//--- hdl/reg_access_if.sv
`timescale 1ns/1ps

// Decoded register accesses between the bus responder and the register bank
interface reg_access_if;

    logic                     wr_xfer;    // One-cycle write strobes
    logic                     wr_pwr;
    logic                     wr_gpio;
    logic                     wr_ctrl;
    mprj_ctrl_pkg::pad_idx_t  ctrl_idx;   // Pad addressed by the current access
    mprj_ctrl_pkg::bus_data_t wdata;

    // Read-back from the bank
    mprj_ctrl_pkg::pwr_vec_t  pwr;
    mprj_ctrl_pkg::pad_vec_t  gpio_out;   // Raw GPIO output data register
    mprj_ctrl_pkg::pad_ctrl_t ctrl_rd;    // Control word of pad ctrl_idx

    modport resp (
        output wr_xfer, wr_pwr, wr_gpio, wr_ctrl, ctrl_idx, wdata,
        input  pwr, gpio_out, ctrl_rd
    );

    modport bank (
        input  wr_xfer, wr_pwr, wr_gpio, wr_ctrl, ctrl_idx, wdata,
        output pwr, gpio_out, ctrl_rd
    );

endinterface

//--- hdl/mprj_bus_resp.sv
`timescale 1ns/1ps

module mprj_bus_resp (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     valid_i,
    input  mprj_ctrl_pkg::bus_addr_t addr_i,
    input  logic [1:0]               wstrb_i,
    input  mprj_ctrl_pkg::bus_data_t wdata_i,
    input  logic                     busy_i,
    input  mprj_ctrl_pkg::pad_vec_t  gpio_in_i,
    output mprj_ctrl_pkg::bus_data_t rdata_o,
    output logic                     ready_o,
    reg_access_if.resp               bank
);

    logic [7:0]               ofs;
    logic [7:0]               ctrl_ofs;     // Offset relative to the first control word
    logic                     base_hit;
    logic                     take;
    logic                     wr_en;
    logic                     xfer_sel;
    logic                     pwr_sel;
    logic                     gpio_sel;
    logic                     ctrl_sel;
    mprj_ctrl_pkg::bus_data_t rd_mux;

    assign ofs      = addr_i[7:0];
    assign ctrl_ofs = ofs - mprj_ctrl_pkg::IOCONFIG_OFS;
    assign base_hit = (addr_i[31:8] == mprj_ctrl_pkg::BASE_ADR[31:8]);
    assign take     = valid_i && !ready_o && base_hit;
    assign wr_en    = take && wstrb_i[0];   // Only whole-word writes

    assign xfer_sel = (ofs == mprj_ctrl_pkg::XFER_OFS);
    assign pwr_sel  = (ofs == mprj_ctrl_pkg::PWRDATA_OFS);
    assign gpio_sel = (ofs == mprj_ctrl_pkg::IODATA_OFS);
    assign ctrl_sel = (ofs >= mprj_ctrl_pkg::IOCONFIG_OFS)
                   && (ctrl_ofs < 8'(4 * mprj_ctrl_pkg::IO_PADS))
                   && (ctrl_ofs[1:0] == 2'b00);

    // Write strobes towards the bank
    assign bank.wr_xfer  = wr_en && xfer_sel;
    assign bank.wr_pwr   = wr_en && pwr_sel;
    assign bank.wr_gpio  = wr_en && gpio_sel;
    assign bank.wr_ctrl  = wr_en && ctrl_sel;
    assign bank.ctrl_idx = ctrl_ofs[2 +: $bits(mprj_ctrl_pkg::pad_idx_t)];
    assign bank.wdata    = wdata_i;

    // Read mux, unmapped offsets return zero
    always_comb begin
        rd_mux = '0;
        if (xfer_sel) begin
            rd_mux[0] = busy_i;
        end else if (pwr_sel) begin
            rd_mux[mprj_ctrl_pkg::PWR_PADS-1:0] = bank.pwr;
        end else if (gpio_sel) begin
            // Pin inputs in the low byte, output data register above them
            rd_mux[mprj_ctrl_pkg::IO_PADS-1:0]                   = gpio_in_i;
            rd_mux[mprj_ctrl_pkg::IO_PADS +: mprj_ctrl_pkg::IO_PADS] = bank.gpio_out;
        end else if (ctrl_sel) begin
            rd_mux[mprj_ctrl_pkg::IO_CTRL_BITS-1:0] = bank.ctrl_rd;
        end
    end

    // Ready pulses for one cycle after an accepted access
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            ready_o <= 1'b0;
        end else begin
            ready_o <= take;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            rdata_o <= rd_mux;
        end
    end

endmodule

//--- hdl/mprj_reg_bank.sv
`timescale 1ns/1ps

module mprj_reg_bank (
    input  logic                      clk,
    input  logic                      resetn,
    reg_access_if.bank                bank,
    input  mprj_ctrl_pkg::pad_idx_t   pad_idx_i,
    output mprj_ctrl_pkg::pad_ctrl_t  pad_word_o,
    output logic                      xfer_go_o,
    output mprj_ctrl_pkg::pad_vec_t   gpio_out_o,
    output mprj_ctrl_pkg::pwr_vec_t   pwr_ctrl_o,
    output logic                      sdo_oenb_state_o,
    output logic                      jtag_oenb_state_o
);

    mprj_ctrl_pkg::pad_ctrl_t io_ctrl [mprj_ctrl_pkg::IO_PADS];
    mprj_ctrl_pkg::pad_vec_t  gpio_data;
    mprj_ctrl_pkg::pad_vec_t  inp_dis;     // Input-disable bit of every pad
    mprj_ctrl_pkg::pwr_vec_t  pwr_data;
    logic                     xfer_ctrl;

    // Pad control words
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            for (int i = 0; i < mprj_ctrl_pkg::IO_PADS; i++) begin
                if (i < 2) begin
                    io_ctrl[i] <= mprj_ctrl_pkg::CTRL_RST_BIDIR;
                end else begin
                    io_ctrl[i] <= mprj_ctrl_pkg::CTRL_RST_INPUT;
                end
            end
        end else if (bank.wr_ctrl) begin
            io_ctrl[bank.ctrl_idx] <= bank.wdata[mprj_ctrl_pkg::IO_CTRL_BITS-1:0];
        end
    end

    // GPIO data, power bits and the transfer request
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            gpio_data <= '0;
            pwr_data  <= '0;
            xfer_ctrl <= 1'b0;
        end else begin
            if (bank.wr_gpio) begin
                gpio_data <= bank.wdata[mprj_ctrl_pkg::IO_PADS-1:0];
            end
            if (bank.wr_pwr) begin
                pwr_data <= bank.wdata[mprj_ctrl_pkg::PWR_PADS-1:0];
            end
            // Self-clearing, high for a single cycle
            xfer_ctrl <= bank.wr_xfer && bank.wdata[0];
        end
    end

    always_comb begin
        for (int i = 0; i < mprj_ctrl_pkg::IO_PADS; i++) begin
            inp_dis[i] = io_ctrl[i][mprj_ctrl_pkg::INP_DIS_BIT];
        end
    end

    // Management drives a pad only when its input is disabled
    assign gpio_out_o = gpio_data & inp_dis;
    assign pwr_ctrl_o = pwr_data;
    assign xfer_go_o  = xfer_ctrl;
    assign pad_word_o = io_ctrl[pad_idx_i];   // Word for the serial loader

    // OEB state of the JTAG and SDO pads goes back to the core
    assign jtag_oenb_state_o = io_ctrl[0][mprj_ctrl_pkg::OEB_BIT];
    assign sdo_oenb_state_o  = io_ctrl[1][mprj_ctrl_pkg::OEB_BIT];

    // Read-back towards the responder
    assign bank.pwr      = pwr_data;
    assign bank.gpio_out = gpio_data;
    assign bank.ctrl_rd  = io_ctrl[bank.ctrl_idx];

endmodule

//--- hdl/mprj_serial_loader.sv
`timescale 1ns/1ps

// Shifts every pad control word out on the serial chain, highest pad first.
// Each bit takes two cycles (clock low, clock high), then a one-cycle
// latch pulse on serial reset closes the transfer.
module mprj_serial_loader (
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      xfer_go_i,
    input  mprj_ctrl_pkg::pad_ctrl_t  pad_word_i,
    output mprj_ctrl_pkg::pad_idx_t   pad_idx_o,
    output logic                      busy_o,
    output logic                      serial_clock_o,
    output logic                      serial_data_o,
    output logic                      serial_resetn_o
);

    mprj_ctrl_pkg::loader_state_t         state;
    logic [mprj_ctrl_pkg::BIT_CNT_W-1:0]  bit_cnt;
    mprj_ctrl_pkg::pad_idx_t              pad_cnt;
    mprj_ctrl_pkg::pad_ctrl_t             shift_reg;
    logic                                 last_bit;

    assign last_bit = (bit_cnt == mprj_ctrl_pkg::BIT_CNT_W'(mprj_ctrl_pkg::IO_CTRL_BITS - 1));

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state           <= mprj_ctrl_pkg::LDR_IDLE;
            bit_cnt         <= '0;
            pad_cnt         <= mprj_ctrl_pkg::pad_idx_t'(mprj_ctrl_pkg::IO_PADS - 1);
            shift_reg       <= '0;
            serial_clock_o  <= 1'b0;
            serial_resetn_o <= 1'b0;
        end else begin
            case (state)
                mprj_ctrl_pkg::LDR_IDLE: begin
                    pad_cnt         <= mprj_ctrl_pkg::pad_idx_t'(mprj_ctrl_pkg::IO_PADS - 1);
                    serial_clock_o  <= 1'b0;
                    serial_resetn_o <= 1'b1;
                    if (xfer_go_i) begin
                        state <= mprj_ctrl_pkg::LDR_START;
                    end
                end

                mprj_ctrl_pkg::LDR_START: begin
                    shift_reg      <= pad_word_i;   // Word of pad pad_cnt
                    bit_cnt        <= '0;
                    serial_clock_o <= 1'b0;
                    state          <= mprj_ctrl_pkg::LDR_SHIFT;
                end

                mprj_ctrl_pkg::LDR_SHIFT: begin
                    serial_clock_o <= ~serial_clock_o;
                    if (serial_clock_o) begin
                        // Falling edge of the serial clock, move to next bit
                        shift_reg <= {shift_reg[mprj_ctrl_pkg::IO_CTRL_BITS-2:0], 1'b0};
                        bit_cnt   <= bit_cnt + 1'b1;
                        if (last_bit) begin
                            if (pad_cnt == '0) begin
                                serial_resetn_o <= 1'b0;   // Latch pulse next
                                state           <= mprj_ctrl_pkg::LDR_LATCH;
                            end else begin
                                pad_cnt <= pad_cnt - 1'b1;
                                state   <= mprj_ctrl_pkg::LDR_START;
                            end
                        end
                    end
                end

                mprj_ctrl_pkg::LDR_LATCH: begin
                    serial_clock_o  <= 1'b0;
                    serial_resetn_o <= 1'b1;
                    state           <= mprj_ctrl_pkg::LDR_IDLE;
                end

                default: begin
                    state <= mprj_ctrl_pkg::LDR_IDLE;
                end
            endcase
        end
    end

    assign pad_idx_o     = pad_cnt;
    assign busy_o        = (state != mprj_ctrl_pkg::LDR_IDLE);
    assign serial_data_o = shift_reg[mprj_ctrl_pkg::IO_CTRL_BITS-1];   // MSB first

endmodule

//--- hdl/mprj_ctrl_top.sv
`timescale 1ns/1ps

module mprj_ctrl_top (
    input  logic                      clk,
    input  logic                      resetn,

    // Memory-mapped bus
    input  logic                      iomem_valid_i,
    input  mprj_ctrl_pkg::bus_addr_t  iomem_addr_i,
    input  logic [1:0]                iomem_wstrb_i,
    input  mprj_ctrl_pkg::bus_data_t  iomem_wdata_i,
    output mprj_ctrl_pkg::bus_data_t  iomem_rdata_o,
    output logic                      iomem_ready_o,

    // GPIO and power control
    input  mprj_ctrl_pkg::pad_vec_t   mgmt_gpio_in_i,
    output mprj_ctrl_pkg::pad_vec_t   mgmt_gpio_out_o,
    output mprj_ctrl_pkg::pwr_vec_t   pwr_ctrl_o,

    // Serial configuration chain
    output logic                      serial_clock_o,
    output logic                      serial_data_o,
    output logic                      serial_resetn_o,

    output logic                      sdo_oenb_state_o,
    output logic                      jtag_oenb_state_o
);

    reg_access_if              acc ();

    logic                      xfer_go;
    logic                      busy;
    mprj_ctrl_pkg::pad_idx_t   pad_idx;
    mprj_ctrl_pkg::pad_ctrl_t  pad_word;

    mprj_bus_resp u_bus_resp (
        .clk       (clk),
        .resetn    (resetn),
        .valid_i   (iomem_valid_i),
        .addr_i    (iomem_addr_i),
        .wstrb_i   (iomem_wstrb_i),
        .wdata_i   (iomem_wdata_i),
        .busy_i    (busy),
        .gpio_in_i (mgmt_gpio_in_i),
        .rdata_o   (iomem_rdata_o),
        .ready_o   (iomem_ready_o),
        .bank      (acc.resp)
    );

    mprj_reg_bank u_reg_bank (
        .clk               (clk),
        .resetn            (resetn),
        .bank              (acc.bank),
        .pad_idx_i         (pad_idx),
        .pad_word_o        (pad_word),
        .xfer_go_o         (xfer_go),
        .gpio_out_o        (mgmt_gpio_out_o),
        .pwr_ctrl_o        (pwr_ctrl_o),
        .sdo_oenb_state_o  (sdo_oenb_state_o),
        .jtag_oenb_state_o (jtag_oenb_state_o)
    );

    mprj_serial_loader u_serial_loader (
        .clk             (clk),
        .resetn          (resetn),
        .xfer_go_i       (xfer_go),
        .pad_word_i      (pad_word),
        .pad_idx_o       (pad_idx),
        .busy_o          (busy),
        .serial_clock_o  (serial_clock_o),
        .serial_data_o   (serial_data_o),
        .serial_resetn_o (serial_resetn_o)
    );

endmodule

//--- dv/mprj_ctrl_tb.sv
`timescale 1ns/1ps

module mprj_ctrl_tb;

    localparam int ACK_TIMEOUT = 10;    // Cycles allowed between valid and ready
    localparam int XFER_POLLS  = 300;   // XFER reads before the transfer counts as stuck
    localparam int CHAIN_BITS  = mprj_ctrl_pkg::IO_PADS * mprj_ctrl_pkg::IO_CTRL_BITS;

    logic                     clk;
    logic                     resetn;
    logic                     iomem_valid;
    mprj_ctrl_pkg::bus_addr_t iomem_addr;
    logic [1:0]               iomem_wstrb;
    mprj_ctrl_pkg::bus_data_t iomem_wdata;
    mprj_ctrl_pkg::bus_data_t iomem_rdata;
    logic                     iomem_ready;
    mprj_ctrl_pkg::pad_vec_t  gpio_in;
    mprj_ctrl_pkg::pad_vec_t  gpio_out;
    mprj_ctrl_pkg::pwr_vec_t  pwr_ctrl;
    logic                     serial_clock;
    logic                     serial_data;
    logic                     serial_resetn;
    logic                     sdo_oenb;
    logic                     jtag_oenb;

    // Register model
    mprj_ctrl_pkg::pad_ctrl_t ctrl_m [mprj_ctrl_pkg::IO_PADS];
    mprj_ctrl_pkg::pad_vec_t  gpio_m;
    mprj_ctrl_pkg::pwr_vec_t  pwr_m;

    logic                     chain_bits [$];   // Serial chain capture
    int                       latch_cycles;

    mprj_ctrl_top DUT (
        .clk               (clk),
        .resetn            (resetn),
        .iomem_valid_i     (iomem_valid),
        .iomem_addr_i      (iomem_addr),
        .iomem_wstrb_i     (iomem_wstrb),
        .iomem_wdata_i     (iomem_wdata),
        .iomem_rdata_o     (iomem_rdata),
        .iomem_ready_o     (iomem_ready),
        .mgmt_gpio_in_i    (gpio_in),
        .mgmt_gpio_out_o   (gpio_out),
        .pwr_ctrl_o        (pwr_ctrl),
        .serial_clock_o    (serial_clock),
        .serial_data_o     (serial_data),
        .serial_resetn_o   (serial_resetn),
        .sdo_oenb_state_o  (sdo_oenb),
        .jtag_oenb_state_o (jtag_oenb)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // Chain monitor, data is stable across the rising serial clock
    always @(posedge serial_clock) begin
        chain_bits.push_back(serial_data);
    end

    always @(posedge clk) begin
        if (resetn && !serial_resetn) begin
            latch_cycles++;
        end
    end

    task automatic stop_run(input string reason);
        $display("Simulation failed");
        $fatal(1, "%s", reason);
    endtask

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("[ERROR] t=%0t ns %s expected 0x%0h actual 0x%0h", $time, name, exp, act);
            stop_run("Value mismatch");
        end
    endtask

    function automatic mprj_ctrl_pkg::bus_addr_t reg_addr(input logic [7:0] ofs);
        return {mprj_ctrl_pkg::BASE_ADR[31:8], ofs};
    endfunction

    function automatic logic [7:0] ctrl_ofs(input int pad);
        return mprj_ctrl_pkg::IOCONFIG_OFS + 8'(4 * pad);
    endfunction

    // Read value the model predicts while the loader is idle
    function automatic mprj_ctrl_pkg::bus_data_t expected_rdata(input logic [7:0] ofs);
        mprj_ctrl_pkg::bus_data_t val;
        val = '0;
        if (ofs == mprj_ctrl_pkg::PWRDATA_OFS) begin
            val[mprj_ctrl_pkg::PWR_PADS-1:0] = pwr_m;
        end else if (ofs == mprj_ctrl_pkg::IODATA_OFS) begin
            val[15:0] = {gpio_m, gpio_in};   // Output data above the pin inputs
        end
        for (int i = 0; i < mprj_ctrl_pkg::IO_PADS; i++) begin
            if (ofs == ctrl_ofs(i)) begin
                val[mprj_ctrl_pkg::IO_CTRL_BITS-1:0] = ctrl_m[i];
            end
        end
        return val;
    endfunction

    // One bus access, inputs change 1 ns after the clock edge
    task automatic bus_access(input mprj_ctrl_pkg::bus_addr_t addr, input logic [1:0] wstrb,
                              input mprj_ctrl_pkg::bus_data_t wdata,
                              output mprj_ctrl_pkg::bus_data_t rdata);
        int waited;
        waited = 0;
        @(posedge clk);
        #1;
        iomem_valid = 1'b1;
        iomem_addr  = addr;
        iomem_wstrb = wstrb;
        iomem_wdata = wdata;
        @(posedge clk);
        #1;
        while (!iomem_ready) begin
            if (waited == ACK_TIMEOUT) begin
                stop_run("No ready from the DUT for an in-range access");
            end
            waited++;
            @(posedge clk);
            #1;
        end
        rdata       = iomem_rdata;
        iomem_valid = 1'b0;
        iomem_wstrb = 2'b00;
    endtask

    task automatic read_expect(input logic [7:0] ofs);
        mprj_ctrl_pkg::bus_data_t rd;
        bus_access(reg_addr(ofs), 2'b00, $urandom, rd);   // Random wdata must be ignored
        compare($sformatf("iomem_rdata_o @%02h", ofs), expected_rdata(ofs), rd);
    endtask

    task automatic verify_outputs();
        mprj_ctrl_pkg::pad_vec_t exp_out;
        for (int i = 0; i < mprj_ctrl_pkg::IO_PADS; i++) begin
            exp_out[i] = gpio_m[i] & ctrl_m[i][mprj_ctrl_pkg::INP_DIS_BIT];
        end
        compare("mgmt_gpio_out_o", 32'(exp_out), 32'(gpio_out));
        compare("pwr_ctrl_o", 32'(pwr_m), 32'(pwr_ctrl));
        compare("jtag_oenb_state_o", 32'(ctrl_m[0][mprj_ctrl_pkg::OEB_BIT]), 32'(jtag_oenb));
        compare("sdo_oenb_state_o", 32'(ctrl_m[1][mprj_ctrl_pkg::OEB_BIT]), 32'(sdo_oenb));
    endtask

    task automatic random_write();
        mprj_ctrl_pkg::bus_data_t data;
        mprj_ctrl_pkg::bus_data_t rd;
        logic [1:0]               wstrb;
        logic [7:0]               ofs;
        int unsigned              sel;
        int                       pad;
        data  = $urandom;
        wstrb = (($urandom % 4) == 0) ? 2'b10 : 2'b11;   // Some writes lack strobe bit 0
        sel   = $urandom % 4;
        pad   = $urandom % mprj_ctrl_pkg::IO_PADS;
        case (sel)
            0:       ofs = mprj_ctrl_pkg::PWRDATA_OFS;
            1:       ofs = mprj_ctrl_pkg::IODATA_OFS;
            default: ofs = ctrl_ofs(pad);
        endcase
        bus_access(reg_addr(ofs), wstrb, data, rd);
        if (wstrb[0]) begin
            case (sel)
                0:       pwr_m = data[mprj_ctrl_pkg::PWR_PADS-1:0];
                1:       gpio_m = data[mprj_ctrl_pkg::IO_PADS-1:0];
                default: ctrl_m[pad] = data[mprj_ctrl_pkg::IO_CTRL_BITS-1:0];
            endcase
        end
        verify_outputs();
        read_expect(ofs);
    endtask

    initial begin
        mprj_ctrl_pkg::bus_data_t rd;
        mprj_ctrl_pkg::bus_data_t data;
        logic                     exp_bits [$];
        int                       polls;
        int                       latch_before;
        void'($urandom(18882));
        resetn      = 1'b0;
        iomem_valid = 1'b0;
        iomem_addr  = '0;
        iomem_wstrb = 2'b00;
        iomem_wdata = '0;
        gpio_in     = '0;
        for (int i = 0; i < mprj_ctrl_pkg::IO_PADS; i++) begin
            ctrl_m[i] = (i < 2) ? mprj_ctrl_pkg::CTRL_RST_BIDIR : mprj_ctrl_pkg::CTRL_RST_INPUT;
        end
        gpio_m = '0;
        pwr_m  = '0;
        repeat (8) @(posedge clk);
        #1;
        resetn = 1'b1;

        // Reset state
        verify_outputs();
        for (int i = 0; i < mprj_ctrl_pkg::IO_PADS; i++) begin
            read_expect(ctrl_ofs(i));
        end
        read_expect(mprj_ctrl_pkg::XFER_OFS);

        repeat (60) random_write();

        // Pin inputs, then random offsets inside the base
        repeat (30) begin
            gpio_in = mprj_ctrl_pkg::pad_vec_t'($urandom);
            read_expect(mprj_ctrl_pkg::IODATA_OFS);
            read_expect(8'($urandom));
        end

        // Serial transfer of freshly written control words
        for (int i = 0; i < mprj_ctrl_pkg::IO_PADS; i++) begin
            data = $urandom;
            bus_access(reg_addr(ctrl_ofs(i)), 2'b01, data, rd);
            ctrl_m[i] = data[mprj_ctrl_pkg::IO_CTRL_BITS-1:0];
        end
        for (int p = mprj_ctrl_pkg::IO_PADS - 1; p >= 0; p--) begin
            for (int b = mprj_ctrl_pkg::IO_CTRL_BITS - 1; b >= 0; b--) begin
                exp_bits.push_back(ctrl_m[p][b]);
            end
        end
        latch_before = latch_cycles;
        bus_access(reg_addr(mprj_ctrl_pkg::XFER_OFS), 2'b01, 32'h1, rd);
        bus_access(reg_addr(mprj_ctrl_pkg::XFER_OFS), 2'b00, 32'h0, rd);
        compare("XFER busy", 32'h1, rd);
        polls = 0;
        while (rd[0]) begin
            if (polls == XFER_POLLS) begin
                stop_run("Serial transfer did not finish in time");
            end
            polls++;
            bus_access(reg_addr(mprj_ctrl_pkg::XFER_OFS), 2'b00, 32'h0, rd);
        end
        compare("serial bit count", CHAIN_BITS, chain_bits.size());
        for (int i = 0; i < CHAIN_BITS; i++) begin
            compare($sformatf("serial_data_o bit %0d", i), 32'(exp_bits[i]), 32'(chain_bits[i]));
        end
        compare("serial_resetn_o low cycles", 32'h1, 32'(latch_cycles - latch_before));

        // Write outside the base, must never be acknowledged
        @(posedge clk);
        #1;
        iomem_valid = 1'b1;
        iomem_addr  = {8'h24, 16'($urandom), mprj_ctrl_pkg::PWRDATA_OFS};
        iomem_wstrb = 2'b01;
        iomem_wdata = $urandom;
        repeat (20) begin
            @(posedge clk);
            #1;
            if (iomem_ready) begin
                stop_run("Access outside the base address was acknowledged");
            end
        end
        iomem_valid = 1'b0;
        iomem_wstrb = 2'b00;
        read_expect(mprj_ctrl_pkg::PWRDATA_OFS);
        verify_outputs();

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- filelist.f
hdl/mprj_ctrl_pkg.sv
hdl/reg_access_if.sv
hdl/mprj_bus_resp.sv
hdl/mprj_reg_bank.sv
hdl/mprj_serial_loader.sv
hdl/mprj_ctrl_top.sv
dv/mprj_ctrl_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := mprj_ctrl_tb
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing -j 0 --Mdir $(OBJ_DIR) --top-module $(TOP)

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
